/* tests/pad_cases.txt */
// name  width(dec)  src_base(hex)  dst_base(hex)
// regions of one case must not overlap and must stay below 0x10000
w4_small    4   00000000  00004000
w6_offset   6   00000100  00005000
w62_full    62  00000000  00008000
w8_mid      8   00002000  00003000
w4_again    4   0000f000  0000e000

/* all.f */
design/pad_dma_pkg.sv
design/pad_dma_sequencer.sv
design/window_fetch.sv
design/block_mapper.sv
design/block_writer.sv
design/pad_dma_top.sv
tests/tb_clock.sv
tests/axi_mem_model.sv
tests/pad_dma_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing
TOP       := pad_dma_tb
FILELIST  := all.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/pad_dma_tb.sv */
/*
 * Testbench for the mirror-padding DMA. Reads cases from tests/pad_cases.txt,
 * loads a random source matrix, runs the DUT and checks the padded copy, the
 * untouched memory and the order of the writes on the bus.
 */
`timescale 1ns/1ps

module pad_dma_tb;

    localparam int MEM_WORDS = 16384;

    logic        clk;
    logic        rst_n;
    logic [31:0] src_addr;
    logic [31:0] dst_addr;
    logic [5:0]  mat_width;
    logic        start;
    logic        done;
    logic [31:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic        rlast;
    logic        rvalid;
    logic        rready;
    logic [31:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic        wvalid;
    logic        wready;
    logic        bvalid;
    logic        bready;

    string       case_name [$];
    int          case_w [$];
    logic [31:0] case_src [$];
    logic [31:0] case_dst [$];
    logic [31:0] src_copy [0:4095];
    logic [31:0] exp_waddr [$];
    logic [31:0] aw_seen [$];
    string       cur_name;
    int          err_cnt;
    int          limit_cycles;
    integer      seed;

    tb_clock clock_inst (.clk_o(clk));

    axi_mem_model #(.MEM_WORDS(MEM_WORDS)) mem_inst (
        .clk(clk), .rst_n(rst_n),
        .araddr_i(araddr), .arvalid_i(arvalid), .arready_o(arready),
        .rdata_o(rdata), .rlast_o(rlast), .rvalid_o(rvalid), .rready_i(rready),
        .awaddr_i(awaddr), .awvalid_i(awvalid), .awready_o(awready),
        .wdata_i(wdata), .wvalid_i(wvalid), .wready_o(wready),
        .bvalid_o(bvalid), .bready_i(bready)
    );

    pad_dma_top pad_dma_top_inst (
        .clk(clk), .rst_n(rst_n),
        .src_addr_i(src_addr), .dst_addr_i(dst_addr), .mat_width_i(mat_width),
        .start_i(start), .done_o(done),
        .araddr_o(araddr), .arvalid_o(arvalid), .arready_i(arready),
        .rdata_i(rdata), .rlast_i(rlast), .rvalid_i(rvalid), .rready_o(rready),
        .awaddr_o(awaddr), .awvalid_o(awvalid), .awready_i(awready),
        .wdata_o(wdata), .wvalid_o(wvalid), .wready_i(wready),
        .bvalid_i(bvalid), .bready_o(bready)
    );

    task automatic compare(input string tname, input string what,
                           input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s %s expected %h actual %h", tname, what, expected, actual);
            err_cnt++;
        end
    endtask

    function automatic int clamp_index(input int v, input int lo, input int hi);
        return (v < lo) ? lo : ((v > hi) ? hi : v);
    endfunction

    // distinct per address so a stray write to any word shows up
    function automatic logic [31:0] sentinel(input int idx);
        return {16'h5E47, 16'(idx)};
    endfunction

    // write data may only be valid after its AW transfer, and each write
    // hits the next address of the walk
    always @(posedge clk) begin
        if (awvalid && awready) begin
            aw_seen.push_back(awaddr);
        end
        if (wvalid && aw_seen.size() == 0) begin
            $display("write data valid before its address in case %s", cur_name);
            err_cnt++;
        end else if (wvalid && wready) begin
            if (exp_waddr.size() == 0) begin
                $display("unexpected extra write to %h in case %s", aw_seen[0], cur_name);
                void'(aw_seen.pop_front());
                err_cnt++;
            end else begin
                compare(cur_name, "write addr", exp_waddr.pop_front(), aw_seen.pop_front());
            end
        end
    end

    task automatic load_cases();
        int    fd;
        int    w;
        string line;
        string nm;
        logic [31:0] s;
        logic [31:0] d;
        fd = $fopen("tests/pad_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open tests/pad_cases.txt");
            err_cnt++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 2 && line.substr(0, 1) != "//") begin
                if ($sscanf(line, "%s %d %h %h", nm, w, s, d) == 4) begin
                    case_name.push_back(nm);
                    case_w.push_back(w);
                    case_src.push_back(s);
                    case_dst.push_back(d);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic prepare_case(input int w, input logic [31:0] src, input logic [31:0] dst);
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_inst.mem[i] = sentinel(i);
        end
        for (int i = 0; i < w * w; i++) begin
            src_copy[i] = $random(seed);
            mem_inst.mem[(src >> 2) + i] = src_copy[i];
        end
        // block walk in row-major order, TL TR BL BR inside a block
        exp_waddr.delete();
        aw_seen.delete();
        for (int br = 0; br <= w; br += 2) begin
            for (int bc = 0; bc <= w; bc += 2) begin
                for (int k = 0; k < 4; k++) begin
                    exp_waddr.push_back(dst + ((br + k / 2) * (w + 2) + bc + k % 2) * 4);
                end
            end
        end
    endtask

    task automatic check_memory(input int w, input logic [31:0] src, input logic [31:0] dst);
        int          pw;
        int          k;
        logic [31:0] a;
        logic [31:0] expected;
        pw = w + 2;
        for (int i = 0; i < MEM_WORDS; i++) begin
            a = i * 4;
            if (a >= dst && a < dst + pw * pw * 4) begin
                k = (a - dst) / 4;
                expected = src_copy[(clamp_index(k / pw, 1, w) - 1) * w
                                    + clamp_index(k % pw, 1, w) - 1];
            end else if (a >= src && a < src + w * w * 4) begin
                expected = src_copy[(a - src) / 4];
            end else begin
                expected = sentinel(i);
            end
            compare(cur_name, $sformatf("mem[%h]", a), expected, mem_inst.mem[i]);
        end
    endtask

    task automatic run_case(input int n);
        cur_name = case_name[n];
        prepare_case(case_w[n], case_src[n], case_dst[n]);
        @(posedge clk);
        #1;
        src_addr  = case_src[n];
        dst_addr  = case_dst[n];
        mat_width = 6'(case_w[n]);
        start     = 1'b1;
        @(posedge clk);
        #1 start = 1'b0;
        compare(cur_name, "done after start", 32'd0, 32'(done));
        @(posedge clk);
        while (done !== 1'b1) @(posedge clk);
        if (exp_waddr.size() != 0) begin
            $display("case %s ended with %0d writes missing", cur_name, exp_waddr.size());
            err_cnt++;
        end
        check_memory(case_w[n], case_src[n], case_dst[n]);
    endtask

    initial begin
        seed         = 6;
        err_cnt      = 0;
        limit_cycles = 0;
        cur_name     = "reset";
        rst_n        = 1'b0;
        src_addr     = '0;
        dst_addr     = '0;
        mat_width    = '0;
        start        = 1'b0;
        load_cases();
        for (int n = 0; n < case_w.size(); n++) begin
            limit_cycles += (case_w[n] / 2 + 1) * (case_w[n] / 2 + 1) * 200;
        end
        limit_cycles += 100;
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
        compare("reset", "done after reset", 32'd1, 32'(done));
        for (int n = 0; n < case_w.size(); n++) begin
            run_case(n);
        end
        compare("all", "stray writes", 32'd0, 32'(mem_inst.stray_writes));
        $display("cases: %0d, errors: %0d", case_w.size(), err_cnt);
        if (err_cnt == 0 && case_w.size() > 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // watchdog sized from the widths of all cases
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout: DUT did not finish within %0d cycles in case %s",
                 limit_cycles, cur_name);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

/* tests/axi_mem_model.sv */
/*
 * AXI memory slave for the padding DMA testbench. Serves 3-beat read bursts and
 * single-beat writes with random 0-3 cycle delays on every ready and R/B valid.
 * The testbench loads and inspects mem through hierarchical references.
 */
`timescale 1ns/1ps

module axi_mem_model #(
    parameter int MEM_WORDS = 16384
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] araddr_i,
    input  logic        arvalid_i,
    output logic        arready_o,
    output logic [31:0] rdata_o,
    output logic        rlast_o,
    output logic        rvalid_o,
    input  logic        rready_i,
    input  logic [31:0] awaddr_i,
    input  logic        awvalid_i,
    output logic        awready_o,
    input  logic [31:0] wdata_i,
    input  logic        wvalid_i,
    output logic        wready_o,
    output logic        bvalid_o,
    input  logic        bready_i
);

    logic [31:0] mem [0:MEM_WORDS-1];
    integer      seed;
    integer      stray_writes;
    logic [31:0] rd_addr;
    logic [31:0] wr_addr;

    initial begin
        seed         = 6;
        stray_writes = 0;
        arready_o    = 1'b0;
        rdata_o      = '0;
        rlast_o      = 1'b0;
        rvalid_o     = 1'b0;
        awready_o    = 1'b0;
        wready_o     = 1'b0;
        bvalid_o     = 1'b0;
    end

    // read side, one burst at a time
    always begin
        @(posedge clk);
        if (rst_n && arvalid_i) begin
            repeat ({$random(seed)} % 4) @(posedge clk);
            #1 arready_o = 1'b1;
            @(posedge clk);
            rd_addr = araddr_i;
            #1 arready_o = 1'b0;
            for (int beat = 0; beat < 3; beat++) begin
                repeat ({$random(seed)} % 4) @(posedge clk);
                #1;
                rdata_o  = mem[(rd_addr >> 2) + beat];
                rlast_o  = (beat == 2);
                rvalid_o = 1'b1;
                @(posedge clk);
                while (!rready_i) @(posedge clk);
                #1 rvalid_o = 1'b0;
                rlast_o = 1'b0;
            end
        end
    end

    // write side: address, data, then response
    always begin
        @(posedge clk);
        if (rst_n && awvalid_i) begin
            repeat ({$random(seed)} % 4) @(posedge clk);
            #1 awready_o = 1'b1;
            @(posedge clk);
            wr_addr = awaddr_i;
            #1 awready_o = 1'b0;
            repeat ({$random(seed)} % 4) @(posedge clk);
            #1 wready_o = 1'b1;
            @(posedge clk);
            while (!wvalid_i) @(posedge clk);
            if ((wr_addr >> 2) < MEM_WORDS) begin
                mem[wr_addr >> 2] = wdata_i;
            end else begin
                stray_writes = stray_writes + 1;
            end
            #1 wready_o = 1'b0;
            repeat ({$random(seed)} % 4) @(posedge clk);
            #1 bvalid_o = 1'b1;
            @(posedge clk);
            while (!bready_i) @(posedge clk);
            #1 bvalid_o = 1'b0;
        end
    end

endmodule

/* tests/tb_clock.sv */
/*
 * Free-running testbench clock, 20 ns period.
 */
`timescale 1ns/1ps

module tb_clock (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;
    end

endmodule

/* design/pad_dma_top.sv */
/*
 * Mirror-padding DMA engine top level. Connects the register interface and the
 * AXI read/write ports to the sequencer, window fetch, mapper and block writer.
 */
`timescale 1ns/1ps

module pad_dma_top (
    input  logic                clk,
    input  logic                rst_n,
    input  pad_dma_pkg::addr_t  src_addr_i,
    input  pad_dma_pkg::addr_t  dst_addr_i,
    input  pad_dma_pkg::width_t mat_width_i,
    input  logic                start_i,
    output logic                done_o,
    output pad_dma_pkg::addr_t  araddr_o,
    output logic                arvalid_o,
    input  logic                arready_i,
    input  pad_dma_pkg::word_t  rdata_i,
    input  logic                rlast_i,
    input  logic                rvalid_i,
    output logic                rready_o,
    output pad_dma_pkg::addr_t  awaddr_o,
    output logic                awvalid_o,
    input  logic                awready_i,
    output pad_dma_pkg::word_t  wdata_o,
    output logic                wvalid_o,
    input  logic                wready_i,
    input  logic                bvalid_i,
    output logic                bready_o
);
    import pad_dma_pkg::*;

    dma_cfg_t    cfg;
    win_origin_t origin;
    block_pos_t  pos;
    window_t     window;
    out_block_t  block;
    rd_beat_t    rd_beat;
    logic        fetch_req;
    logic        fetch_ack;
    logic        write_req;
    logic        write_ack;

    assign rd_beat = '{data: rdata_i, last: rlast_i};

    pad_dma_sequencer u_sequencer (
        .clk         (clk),
        .rst_n       (rst_n),
        .src_addr_i  (src_addr_i),
        .dst_addr_i  (dst_addr_i),
        .mat_width_i (mat_width_i),
        .start_i     (start_i),
        .done_o      (done_o),
        .cfg_o       (cfg),
        .fetch_req_o (fetch_req),
        .origin_o    (origin),
        .fetch_ack_i (fetch_ack),
        .write_req_o (write_req),
        .pos_o       (pos),
        .write_ack_i (write_ack)
    );

    window_fetch u_fetch (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_i     (cfg),
        .req_i     (fetch_req),
        .origin_i  (origin),
        .ack_o     (fetch_ack),
        .window_o  (window),
        .araddr_o  (araddr_o),
        .arvalid_o (arvalid_o),
        .arready_i (arready_i),
        .rd_i      (rd_beat),
        .rvalid_i  (rvalid_i),
        .rready_o  (rready_o)
    );

    block_mapper u_mapper (
        .cfg_i    (cfg),
        .pos_i    (pos),
        .origin_i (origin),
        .window_i (window),
        .block_o  (block)
    );

    block_writer u_writer (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_i     (write_req),
        .block_i   (block),
        .ack_o     (write_ack),
        .awaddr_o  (awaddr_o),
        .awvalid_o (awvalid_o),
        .awready_i (awready_i),
        .wdata_o   (wdata_o),
        .wvalid_o  (wvalid_o),
        .wready_i  (wready_i),
        .bvalid_i  (bvalid_i),
        .bready_o  (bready_o)
    );

endmodule

/* design/block_writer.sv */
/*
 * AXI write master for one output block. Latches the block on request and sends
 * the four words TL, TR, BL, BR as single-beat writes, one response at a time.
 */
`timescale 1ns/1ps

module block_writer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req_i,
    input  pad_dma_pkg::out_block_t block_i,
    output logic                    ack_o,
    output pad_dma_pkg::addr_t      awaddr_o,
    output logic                    awvalid_o,
    input  logic                    awready_i,
    output pad_dma_pkg::word_t      wdata_o,
    output logic                    wvalid_o,
    input  logic                    wready_i,
    input  logic                    bvalid_i,
    output logic                    bready_o
);
    import pad_dma_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_DATA,
        ST_ACK
    } state_t;

    state_t     state;
    out_block_t blk_q;
    // word index, also counts the B responses seen
    logic [1:0] word_cnt;

    assign awaddr_o = blk_q.addr[word_cnt];
    assign wdata_o  = blk_q.data[word_cnt];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            ack_o     <= 1'b0;
            awvalid_o <= 1'b0;
            wvalid_o  <= 1'b0;
            bready_o  <= 1'b0;
            word_cnt  <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req_i) begin
                        word_cnt  <= '0;
                        awvalid_o <= 1'b1;
                        state     <= ST_ADDR;
                    end
                end
                ST_ADDR: begin
                    if (awready_i) begin
                        awvalid_o <= 1'b0;
                        wvalid_o  <= 1'b1;
                        bready_o  <= 1'b1;
                        state     <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (wvalid_o && wready_i) begin
                        wvalid_o <= 1'b0;
                    end
                    if (bvalid_i) begin
                        bready_o <= 1'b0;
                        if (word_cnt == 2'd3) begin
                            ack_o <= 1'b1;
                            state <= ST_ACK;
                        end else begin
                            word_cnt  <= word_cnt + 2'd1;
                            awvalid_o <= 1'b1;
                            state     <= ST_ADDR;
                        end
                    end
                end
                ST_ACK: begin
                    if (!req_i) begin
                        ack_o <= 1'b0;
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && req_i) begin
            blk_q <= block_i;
        end
    end

endmodule

/* design/block_mapper.sv */
/*
 * Combinational padding map for one 2x2 output block. Clamps each output
 * coordinate into the source range, picks the word from the fetched window and
 * computes its padded-matrix destination address.
 */
`timescale 1ns/1ps

module block_mapper (
    input  pad_dma_pkg::dma_cfg_t    cfg_i,
    input  pad_dma_pkg::block_pos_t  pos_i,
    input  pad_dma_pkg::win_origin_t origin_i,
    input  pad_dma_pkg::window_t     window_i,
    output pad_dma_pkg::out_block_t  block_o
);
    import pad_dma_pkg::*;

    coord_t width_c;
    addr_t  pad_width;

    assign width_c   = coord_t'(cfg_i.mat_width);
    assign pad_width = addr_t'(cfg_i.mat_width) + addr_t'(2);

    always_comb begin
        coord_t     out_r;
        coord_t     out_c;
        coord_t     rel_r;
        coord_t     rel_c;
        logic [3:0] win_idx;

        block_o = '0;
        for (int k = 0; k < BLK_DIM * BLK_DIM; k++) begin
            out_r = pos_i.row + coord_t'(k / BLK_DIM);
            out_c = pos_i.col + coord_t'(k % BLK_DIM);

            // padding rows/columns reuse the nearest edge word
            rel_r = clamp_coord(out_r, coord_t'(1), width_c) - origin_i.row;
            rel_c = clamp_coord(out_c, coord_t'(1), width_c) - origin_i.col;

            win_idx         = rel_r[1:0] * 4'(WIN_DIM) + 4'(rel_c[1:0]);
            block_o.data[k] = window_i[win_idx];

            // dst + (r * (W+2) + c) * 4
            block_o.addr[k] = cfg_i.dst_base
                              + (addr_t'(out_r) * pad_width + addr_t'(out_c))
                              * addr_t'(BYTES_PER_WORD);
        end
    end

endmodule

/* design/window_fetch.sv */
/*
 * AXI read master for the 3x3 source window. Issues one 3-beat burst per window
 * row and stores the beats row-major. The window holds until the next request.
 */
`timescale 1ns/1ps

module window_fetch (
    input  logic                     clk,
    input  logic                     rst_n,
    input  pad_dma_pkg::dma_cfg_t    cfg_i,
    input  logic                     req_i,
    input  pad_dma_pkg::win_origin_t origin_i,
    output logic                     ack_o,
    output pad_dma_pkg::window_t     window_o,
    output pad_dma_pkg::addr_t       araddr_o,
    output logic                     arvalid_o,
    input  logic                     arready_i,
    input  pad_dma_pkg::rd_beat_t    rd_i,
    input  logic                     rvalid_i,
    output logic                     rready_o
);
    import pad_dma_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_DATA,
        ST_ACK
    } state_t;

    state_t     state;
    logic [1:0] row_cnt;
    logic [1:0] beat_cnt;
    logic [3:0] win_idx;
    addr_t      row_off;

    // word offset of the current window row start inside the source matrix
    assign row_off = (addr_t'(origin_i.row) + addr_t'(row_cnt) - addr_t'(1))
                     * addr_t'(cfg_i.mat_width)
                     + addr_t'(origin_i.col) - addr_t'(1);
    assign araddr_o = cfg_i.src_base + row_off * addr_t'(BYTES_PER_WORD);
    assign win_idx  = row_cnt * 4'(WIN_DIM) + 4'(beat_cnt);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            ack_o     <= 1'b0;
            arvalid_o <= 1'b0;
            rready_o  <= 1'b0;
            row_cnt   <= '0;
            beat_cnt  <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req_i) begin
                        row_cnt   <= '0;
                        arvalid_o <= 1'b1;
                        state     <= ST_ADDR;
                    end
                end
                ST_ADDR: begin
                    if (arready_i) begin
                        arvalid_o <= 1'b0;
                        rready_o  <= 1'b1;
                        beat_cnt  <= '0;
                        state     <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (rvalid_i) begin
                        beat_cnt <= beat_cnt + 2'd1;
                        if (rd_i.last) begin
                            rready_o <= 1'b0;
                            if (row_cnt == 2'(WIN_DIM - 1)) begin
                                ack_o <= 1'b1;
                                state <= ST_ACK;
                            end else begin
                                row_cnt   <= row_cnt + 2'd1;
                                arvalid_o <= 1'b1;
                                state     <= ST_ADDR;
                            end
                        end
                    end
                end
                ST_ACK: begin
                    if (!req_i) begin
                        ack_o <= 1'b0;
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // rready_o is high throughout ST_DATA
    always_ff @(posedge clk) begin
        if (state == ST_DATA && rvalid_i) begin
            window_o[win_idx] <= rd_i.data;
        end
    end

endmodule

/* design/pad_dma_sequencer.sv */
/*
 * Block walk controller. Latches the configuration on start, then for every 2x2
 * output block runs one window fetch and one block write through req/ack handshakes.
 */
`timescale 1ns/1ps

module pad_dma_sequencer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  pad_dma_pkg::addr_t       src_addr_i,
    input  pad_dma_pkg::addr_t       dst_addr_i,
    input  pad_dma_pkg::width_t      mat_width_i,
    input  logic                     start_i,
    output logic                     done_o,
    output pad_dma_pkg::dma_cfg_t    cfg_o,
    output logic                     fetch_req_o,
    output pad_dma_pkg::win_origin_t origin_o,
    input  logic                     fetch_ack_i,
    output logic                     write_req_o,
    output pad_dma_pkg::block_pos_t  pos_o,
    input  logic                     write_ack_i
);
    import pad_dma_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FETCH,
        ST_WRITE,
        ST_ADVANCE
    } state_t;

    state_t     state;
    dma_cfg_t   cfg_q;
    block_pos_t pos_q;
    coord_t     width_c;

    assign width_c  = coord_t'(cfg_q.mat_width);
    assign cfg_o    = cfg_q;
    assign pos_o    = pos_q;

    // keep the 3x3 window inside the source matrix
    assign origin_o.row = clamp_coord(pos_q.row, coord_t'(1), width_c - coord_t'(2));
    assign origin_o.col = clamp_coord(pos_q.col, coord_t'(1), width_c - coord_t'(2));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= ST_IDLE;
            done_o      <= 1'b1;
            fetch_req_o <= 1'b0;
            write_req_o <= 1'b0;
            cfg_q       <= '0;
            pos_q       <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start_i) begin
                        cfg_q       <= '{src_base: src_addr_i, dst_base: dst_addr_i,
                                         mat_width: mat_width_i};
                        pos_q       <= '0;
                        done_o      <= 1'b0;
                        fetch_req_o <= 1'b1;
                        state       <= ST_FETCH;
                    end
                end
                ST_FETCH: begin
                    if (fetch_req_o && fetch_ack_i) begin
                        fetch_req_o <= 1'b0;
                    end else if (!fetch_req_o && !fetch_ack_i) begin
                        // window is held by the fetch until its next request
                        write_req_o <= 1'b1;
                        state       <= ST_WRITE;
                    end
                end
                ST_WRITE: begin
                    if (write_req_o && write_ack_i) begin
                        write_req_o <= 1'b0;
                    end else if (!write_req_o && !write_ack_i) begin
                        state <= ST_ADVANCE;
                    end
                end
                ST_ADVANCE: begin
                    if (pos_q.col != width_c) begin
                        pos_q.col   <= pos_q.col + coord_t'(BLK_DIM);
                        fetch_req_o <= 1'b1;
                        state       <= ST_FETCH;
                    end else if (pos_q.row != width_c) begin
                        pos_q.col   <= '0;
                        pos_q.row   <= pos_q.row + coord_t'(BLK_DIM);
                        fetch_req_o <= 1'b1;
                        state       <= ST_FETCH;
                    end else begin
                        // bottom-right block written
                        done_o <= 1'b1;
                        state  <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

/* design/pad_dma_pkg.sv */
/*
 * Shared widths, geometry constants and payload structs for the mirror-padding DMA.
 * Every design module imports this package.
 */
package pad_dma_pkg;

    localparam int ADDR_W         = 32;
    localparam int DATA_W         = 32;
    localparam int BYTES_PER_WORD = 4;
    localparam int WIDTH_W        = 6;
    localparam int COORD_W        = 7;
    // window side, also the beat count of every read burst
    localparam int WIN_DIM        = 3;
    localparam int BLK_DIM        = 2;

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [DATA_W-1:0]  word_t;
    typedef logic [WIDTH_W-1:0] width_t;
    typedef logic [COORD_W-1:0] coord_t;

    typedef struct packed {
        addr_t  src_base;
        addr_t  dst_base;
        width_t mat_width;
    } dma_cfg_t;

    // 1-based source row/column of the window's top-left word
    typedef struct packed {
        coord_t row;
        coord_t col;
    } win_origin_t;

    // 0-based padded-matrix position of the block's top-left word
    typedef struct packed {
        coord_t row;
        coord_t col;
    } block_pos_t;

    // index 0 is the top-left word, row-major
    typedef word_t [WIN_DIM*WIN_DIM-1:0] window_t;

    // index order is TL, TR, BL, BR
    typedef struct packed {
        word_t [BLK_DIM*BLK_DIM-1:0] data;
        addr_t [BLK_DIM*BLK_DIM-1:0] addr;
    } out_block_t;

    typedef struct packed {
        word_t data;
        logic  last;
    } rd_beat_t;

    function automatic coord_t clamp_coord(input coord_t v, input coord_t lo, input coord_t hi);
        if (v < lo) begin
            return lo;
        end
        if (v > hi) begin
            return hi;
        end
        return v;
    endfunction

endpackage
